// ==== logic/video_fetch.sv ====
// fetch sequencer, DRAM requests inside the fetch window and word latching
`timescale 1ns/1ps

module video_fetch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   c6,
	input  logic [7:0]             cnt_col,
	input  logic [8:0]             hcnt,
	input  logic [8:0]             vcnt,
	input  logic [8:0]             vpix_beg,
	input  logic [8:0]             vpix_end,
	input  logic [4:0]             go_offs,
	input  logic [5:0]             x_tiles,
	input  logic                   nogfx,
	input  logic [3:0]             fetch_sel,
	input  logic [1:0]             fetch_bsl,
	input  logic [31:0]            video_data,
	input  logic                   video_strb,
	output logic                   video_req,
	output video_pkg::video_word_u txt_char,
	output video_pkg::video_word_u pix_word,
	output logic                   word_rdy,
	output logic                   cptr_en
);

	logic [7:0]  col_q;
	logic [7:0]  open_col;
	logic [7:0]  cols_left;
	logic        col_step;
	logic        line_act;
	logic        win_open;
	logic        win_on;
	logic        busy;	// request waiting for strobe
	logic        done;	// current column already requested
	logic        have;	// raw word not yet taken
	logic        take;
	logic [31:0] raw;
	logic [15:0] half;
	logic [7:0]  pick;

	assign col_step = (cnt_col != col_q);
	assign line_act = (vcnt >= vpix_beg) && (vcnt < vpix_end);
	assign open_col = 8'd0 - {4'd0, go_offs[4:1]};	// go_offs pixels ahead
	assign win_open = c6 && !win_on && line_act && (cnt_col == open_col);
	assign video_req = win_on && !nogfx && !busy && (col_step || !done);
	assign take = have && col_step && !video_strb;

	assign half = (|fetch_sel[1:0]) ? raw[15:0] : raw[31:16];
	assign pick = fetch_bsl[0] ? half[15:8] : half[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col_q <= '0;
			win_on <= 1'b0;
			cols_left <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			have <= 1'b0;
			word_rdy <= 1'b0;
			cptr_en <= 1'b0;
		end else begin
			col_q <= cnt_col;
			word_rdy <= take;
			cptr_en <= take;
			if (c6 && hcnt == 9'd0) begin
				win_on <= 1'b0;	// line start
			end else if (win_open) begin
				win_on <= 1'b1;
				cols_left <= {x_tiles, 2'b00};	// four columns per tile
			end else if (win_on && col_step) begin
				if (cols_left == 8'd1)
					win_on <= 1'b0;
				cols_left <= cols_left - 1'b1;
			end
			if (video_req)
				busy <= 1'b1;
			else if (video_strb)
				busy <= 1'b0;
			if (video_req)
				done <= 1'b1;
			else if (col_step || win_open)
				done <= 1'b0;
			if (video_strb)
				have <= 1'b1;
			else if (take)
				have <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (video_strb)
			raw <= video_data;
		if (take) begin
			pix_word <= (fetch_bsl == 2'b10) ? half : {pick, pick};
			if (fetch_bsl == 2'b10 && fetch_sel == 4'b0011)
				txt_char <= half;	// char codes for the glyph address
		end
	end

endmodule

// ==== logic/video_macros.svh ====
// raster totals, DRAM address width and dot-clock divider
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// pixels per line at the c6 rate
`define VID_HTOTAL 448

// lines per frame
`define VID_VTOTAL 320

// DRAM word address width
`define VID_AW 21

// clocks per c6 period, q2 runs at twice that rate
`define VID_DIV 4

`endif

// ==== logic/video_mode.sv ====
// video mode and raster resolution decoder, DRAM address and fetch selectors
`timescale 1ns/1ps
`include "video_macros.svh"

module video_mode (
	input  logic                   q2,
	input  logic                   c6,
	input  logic [7:0]             vconf,
	input  logic [7:0]             vpage,
	input  logic [8:0]             x_offs,
	input  video_pkg::video_word_u txt_char,
	input  logic [7:0]             cnt_col,
	input  logic [8:0]             cnt_row,
	input  logic                   cptr,
	output logic [9:0]             x_offs_mode,
	output logic [8:0]             hpix_beg,
	output logic [8:0]             hpix_end,
	output logic [8:0]             vpix_beg,
	output logic [8:0]             vpix_end,
	output logic [5:0]             x_tiles,
	output logic [4:0]             go_offs,
	output logic [3:0]             fetch_sel,
	output logic [1:0]             fetch_bsl,
	output logic                   hires,
	output video_pkg::rmode_e      render_mode,
	output logic                   nogfx,
	output logic                   pix_stb,
	output logic [`VID_AW-1:0]     video_addr,
	output logic [3:0]             video_bw
);

	video_pkg::vmode_e vmod;
	logic [1:0]        rres;
	logic [8:0]        x_half;
	logic [11:0]       addr_zx_gfx;
	logic [11:0]       addr_zx_atr;
	logic [13:0]       addr_tx;
	logic [3:0]        txt_sel;
	logic [1:0]        txt_bsl;
	logic              is_text;

	assign vmod = video_pkg::vmode_e'(vconf[2:0]);
	assign rres = vconf[7:6];
	assign is_text = (vmod == video_pkg::vm_text);

	assign nogfx = (vmod == video_pkg::vm_nogfx);
	assign hires = is_text || (vmod == video_pkg::vm_zxhr);	// double pixel rate
	assign pix_stb = hires ? q2 : c6;

	// 256c scrolls in whole pixel pairs
	assign x_half = (vmod == video_pkg::vm_256c) ? {x_offs[8:1], 1'b0} : {1'b0, x_offs[8:1]};
	assign x_offs_mode = {x_half, x_offs[0]};

	// fetch lead, bandwidth and shifter mode per video mode
	always_comb begin
		go_offs = 5'd18;
		video_bw = 4'b1001;	// 1 of 8
		render_mode = video_pkg::rm_zx;
		case (vmod)
			video_pkg::vm_16c: begin
				go_offs = 5'd10;
				video_bw = 4'b1010;
				render_mode = video_pkg::rm_16c;
			end
			video_pkg::vm_256c: begin
				go_offs = 5'd6;
				video_bw = 4'b0010;	// 2 of 4
				render_mode = video_pkg::rm_256c;
			end
			video_pkg::vm_text: begin
				go_offs = 5'd10;
				video_bw = 4'b1100;
				render_mode = video_pkg::rm_text;
			end
			video_pkg::vm_giga: video_bw = 4'b1010;
			video_pkg::vm_zxhr: begin
				go_offs = 5'd10;
				video_bw = 4'b1010;
			end
			default: ;
		endcase
	end

	// visible window per raster resolution
	always_comb begin
		case (rres)
			2'd0: begin
				hpix_beg = 9'd140;	// 256 x 192
				hpix_end = 9'd396;
				vpix_beg = 9'd80;
				vpix_end = 9'd272;
				x_tiles = 6'd33;
			end
			2'd1: begin
				hpix_beg = 9'd108;	// 320 x 200
				hpix_end = 9'd428;
				vpix_beg = 9'd76;
				vpix_end = 9'd276;
				x_tiles = 6'd41;
			end
			2'd2: begin
				hpix_beg = 9'd108;	// 320 x 240
				hpix_end = 9'd428;
				vpix_beg = 9'd56;
				vpix_end = 9'd296;
				x_tiles = 6'd41;
			end
			default: begin
				hpix_beg = 9'd88;	// 360 x 288
				hpix_end = 9'd448;
				vpix_beg = 9'd32;
				vpix_end = 9'd320;
				x_tiles = 6'd46;
			end
		endcase
	end

	// zx screen layout, thirds interleaved
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};

	// text phases: char, attr, glyph0, glyph1
	always_comb begin
		case (cnt_col[1:0])
			2'd0: addr_tx = {1'b0, cnt_row[8:3], 1'b0, cnt_col[7:2]};
			2'd1: addr_tx = {1'b0, cnt_row[8:3], 1'b1, cnt_col[7:2]};
			2'd2: addr_tx = {4'b1000, txt_char.chr.char0, cnt_row[2:1]};
			default: addr_tx = {4'b1000, txt_char.chr.char1, cnt_row[2:1]};
		endcase
	end

	always_comb begin
		case (vmod)
			video_pkg::vm_16c: video_addr = {vpage[7:3], cnt_row, cnt_col[6:0]};
			video_pkg::vm_256c: video_addr = {vpage[7:4], cnt_row, cnt_col};
			video_pkg::vm_text: video_addr = {vpage[7:1], addr_tx};
			video_pkg::vm_giga: video_addr = '0;
			default: video_addr = {vpage, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
		endcase
	end

	// column has already moved on when the data is taken
	always_comb begin
		case (cnt_col[1:0])
			2'd1: begin
				txt_sel = 4'b0011;	// char codes
				txt_bsl = 2'b10;
			end
			2'd2: begin
				txt_sel = 4'b1100;	// attributes
				txt_bsl = 2'b10;
			end
			2'd3: begin
				txt_sel = 4'b0001;	// glyph of char0
				txt_bsl = {2{cnt_row[0]}};
			end
			default: begin
				txt_sel = 4'b0010;	// glyph of char1
				txt_bsl = {2{cnt_row[0]}};
			end
		endcase
	end

	assign fetch_sel = is_text ? txt_sel : {~cptr, ~cptr, cptr, cptr};
	assign fetch_bsl = is_text ? txt_bsl : 2'b10;

endmodule

// ==== logic/video_pkg.sv ====
// video mode and render mode enums, fetched word union
package video_pkg;

	// video mode, straight from vconf[2:0]
	typedef enum logic [2:0] {
		vm_zx    = 3'd0,
		vm_16c   = 3'd1,
		vm_256c  = 3'd2,
		vm_text  = 3'd3,
		vm_giga  = 3'd4,	// zx * 2
		vm_zxhr  = 3'd5,	// zx hi-res test
		vm_rsvd  = 3'd6,
		vm_nogfx = 3'd7
	} vmode_e;

	// pixel shifter modes
	typedef enum logic [1:0] {
		rm_zx   = 2'd0,
		rm_16c  = 2'd1,
		rm_256c = 2'd2,
		rm_text = 2'd3
	} rmode_e;

	typedef struct packed {
		logic [7:0] char1;
		logic [7:0] char0;
	} char_pair_t;

	// one 16-bit DRAM word, as two char codes or as four 4-bit pixels
	typedef union packed {
		char_pair_t       chr;
		logic [3:0][3:0]  nib;	// nib[3] is the leftmost pixel
	} video_word_u;

endpackage

// ==== logic/video_render.sv ====
// pixel shifter, serialises fetched words per render mode
`timescale 1ns/1ps

module video_render (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pix_stb,
	input  logic                   pix_en_i,
	input  logic                   nogfx,
	input  video_pkg::rmode_e      render_mode,
	input  video_pkg::video_word_u pix_word,
	input  logic                   word_rdy,
	output logic [7:0]             pix,
	output logic                   pix_en
);

	video_pkg::video_word_u shreg;
	logic [7:0]             pix_q;
	logic [7:0]             pix_next;

	// leftmost pixel of the shifter
	always_comb begin
		case (render_mode)
			video_pkg::rm_16c: pix_next = {4'd0, shreg.nib[3]};
			video_pkg::rm_256c: pix_next = shreg.chr.char1;
			default: pix_next = {7'd0, shreg.nib[3][3]};	// 1 bpp, ink is index 1
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pix_en <= 1'b0;
		else
			pix_en <= pix_en_i;
	end

	always_ff @(posedge clk) begin
		if (word_rdy) begin
			shreg <= pix_word;
		end else if (pix_stb) begin
			case (render_mode)
				video_pkg::rm_16c: shreg <= {shreg[11:0], 4'd0};
				video_pkg::rm_256c: shreg <= {shreg[7:0], 8'd0};
				default: shreg <= {shreg[14:0], 1'b0};
			endcase
		end
		if (pix_stb)
			pix_q <= pix_next;
	end

	// border and blank screen give index 0
	assign pix = (pix_en && !nogfx) ? pix_q : 8'd0;

endmodule

// ==== logic/video_sync.sv ====
// dot-clock strobes, raster counters and window-relative column/row counters
`timescale 1ns/1ps
`include "video_macros.svh"

module video_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [8:0] hpix_beg,
	input  logic [8:0] vpix_beg,
	input  logic [9:0] x_offs_mode,
	input  logic       cptr_en,
	output logic       q2,
	output logic       c6,
	output logic [8:0] hcnt,
	output logic [8:0] vcnt,
	output logic [7:0] cnt_col,
	output logic [8:0] cnt_row,
	output logic       cptr
);

	localparam int DIV_W = $clog2(`VID_DIV);
	localparam int HALF = `VID_DIV / 2;

	logic [DIV_W-1:0] div;
	logic [9:0]       col_pos;
	logic             line_end;
	logic             frame_end;

	// pixel position inside the window, scrolled
	assign col_pos = {1'b0, hcnt} - {1'b0, hpix_beg} + x_offs_mode;
	assign line_end = (hcnt == 9'(`VID_HTOTAL - 1));
	assign frame_end = (vcnt == 9'(`VID_VTOTAL - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div <= '0;
			q2 <= 1'b0;
			c6 <= 1'b0;
		end else begin
			div <= (div == DIV_W'(`VID_DIV - 1)) ? '0 : div + 1'b1;
			q2 <= (int'(div) % HALF) == (HALF - 1);	// twice per c6
			c6 <= (div == DIV_W'(`VID_DIV - 1));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (c6) begin
			if (line_end) begin
				hcnt <= '0;
				vcnt <= frame_end ? '0 : vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// one column is two pixels
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_col <= '0;
			cnt_row <= '0;
			cptr <= 1'b0;
		end else begin
			cnt_col <= col_pos[8:1];
			cnt_row <= vcnt - vpix_beg;
			if (cptr_en)
				cptr <= ~cptr;	// next half of the 32-bit lane pair
		end
	end

endmodule

// ==== logic/video_top.sv ====
// raster video subsystem, sync, mode decoder, fetch and render
`timescale 1ns/1ps
`include "video_macros.svh"

module video_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [7:0]        vconf,
	input  logic [7:0]        vpage,
	input  logic [8:0]        x_offs,
	input  logic [31:0]       video_data,
	input  logic              video_strb,
	output logic              video_req,
	output logic [`VID_AW-1:0] video_addr,
	output logic [3:0]        video_bw,
	output logic [7:0]        pix,
	output logic              pix_en
);

	logic                   q2;
	logic                   c6;
	logic [8:0]             hcnt;
	logic [8:0]             vcnt;
	logic [7:0]             cnt_col;
	logic [8:0]             cnt_row;
	logic                   cptr;
	logic                   cptr_en;
	logic [9:0]             x_offs_mode;
	logic [8:0]             hpix_beg;
	logic [8:0]             hpix_end;
	logic [8:0]             vpix_beg;
	logic [8:0]             vpix_end;
	logic [5:0]             x_tiles;
	logic [4:0]             go_offs;
	logic [3:0]             fetch_sel;
	logic [1:0]             fetch_bsl;
	video_pkg::rmode_e      render_mode;
	logic                   nogfx;
	logic                   pix_stb;
	video_pkg::video_word_u txt_char;
	video_pkg::video_word_u pix_word;
	logic                   word_rdy;
	logic                   pix_en_i;

	// visible area of the raster
	assign pix_en_i = (hcnt >= hpix_beg) && (hcnt < hpix_end) &&
		(vcnt >= vpix_beg) && (vcnt < vpix_end);

	video_sync sync_i (
		.clk(clk), .rst_n(rst_n), .hpix_beg(hpix_beg), .vpix_beg(vpix_beg),
		.x_offs_mode(x_offs_mode), .cptr_en(cptr_en), .q2(q2), .c6(c6),
		.hcnt(hcnt), .vcnt(vcnt), .cnt_col(cnt_col), .cnt_row(cnt_row), .cptr(cptr)
	);

	// hires already selects the pixel strobe inside the decoder
	video_mode mode_i (
		.q2(q2), .c6(c6), .vconf(vconf), .vpage(vpage), .x_offs(x_offs),
		.txt_char(txt_char), .cnt_col(cnt_col), .cnt_row(cnt_row), .cptr(cptr),
		.x_offs_mode(x_offs_mode), .hpix_beg(hpix_beg), .hpix_end(hpix_end),
		.vpix_beg(vpix_beg), .vpix_end(vpix_end), .x_tiles(x_tiles), .go_offs(go_offs),
		.fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl), .hires(),
		.render_mode(render_mode), .nogfx(nogfx), .pix_stb(pix_stb),
		.video_addr(video_addr), .video_bw(video_bw)
	);

	video_fetch fetch_i (
		.clk(clk), .rst_n(rst_n), .c6(c6), .cnt_col(cnt_col), .hcnt(hcnt), .vcnt(vcnt),
		.vpix_beg(vpix_beg), .vpix_end(vpix_end), .go_offs(go_offs), .x_tiles(x_tiles),
		.nogfx(nogfx), .fetch_sel(fetch_sel), .fetch_bsl(fetch_bsl),
		.video_data(video_data), .video_strb(video_strb), .video_req(video_req),
		.txt_char(txt_char), .pix_word(pix_word), .word_rdy(word_rdy), .cptr_en(cptr_en)
	);

	video_render render_i (
		.clk(clk), .rst_n(rst_n), .pix_stb(pix_stb), .pix_en_i(pix_en_i), .nogfx(nogfx),
		.render_mode(render_mode), .pix_word(pix_word), .word_rdy(word_rdy),
		.pix(pix), .pix_en(pix_en)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module video_tb \
	-f video_sub.f --Mdir "$build_dir" -o video_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$build_dir/video_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$log"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1

// ==== test/video_tb.sv ====
// testbench for video_top with DRAM model, assertions, per-test report and watchdog
`timescale 1ns/1ps
`include "video_macros.svh"

module video_tb;

	localparam int TESTS = 6;
	localparam int LIMIT = TESTS * 4 * `VID_VTOTAL * `VID_HTOTAL * `VID_DIV;	// 4 frames each

	logic               clk = 1'b0;
	logic               rst_n;
	logic [7:0]         vconf;
	logic [7:0]         vpage;
	logic [8:0]         x_offs;
	logic [31:0]        video_data = 32'd0;
	logic               video_strb = 1'b0;
	logic               video_req;
	logic [`VID_AW-1:0] video_addr;
	logic [3:0]         video_bw;
	logic [7:0]         pix;
	logic               pix_en;

	int errors = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int cycles = 0;
	int req_cnt = 0;
	int glyph_cnt = 0;

	// DRAM model state
	logic [31:0]        rng = 32'd93;
	logic               pending = 1'b0;
	logic [2:0]         left = 3'd0;
	logic [`VID_AW-1:0] req_addr = '0;

	// text fetch order tracking
	logic               is_text;
	logic               tx_on;
	logic               tx_live = 1'b0;
	logic [1:0]         tx_prev = 2'd0;	// 0 char, 1 attr, 2 glyph0, 3 glyph1
	logic [7:0]         tx_char0 = 8'd0;
	logic [4:0]         tx_gap = 5'd31;
	logic               rst_q = 1'b0;
	logic               rst_old = 1'b0;

	video_top dut_i (
		.clk(clk), .rst_n(rst_n), .vconf(vconf), .vpage(vpage), .x_offs(x_offs),
		.video_data(video_data), .video_strb(video_strb), .video_req(video_req),
		.video_addr(video_addr), .video_bw(video_bw), .pix(pix), .pix_en(pix_en)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory contents, every address bit matters
	function automatic logic [31:0] dram_word(input logic [`VID_AW-1:0] a);
		return {a[20:5] ^ 16'h9e37, a[15:0] + 16'h3c1b};
	endfunction

	function automatic logic [7:0] char0_of(input logic [`VID_AW-1:0] a);
		logic [31:0] w;
		w = dram_word(a);
		return w[7:0];	// low byte of the low half
	endfunction

	function automatic logic bw_listed(input logic [2:0] m);
		return m <= 3'd4;
	endfunction

	function automatic logic [3:0] bw_expect(input logic [2:0] m);
		case (m)
			3'd0: return 4'b1001;
			3'd2: return 4'b0010;
			3'd3: return 4'b1100;
			default: return 4'b1010;	// 16c and giga
		endcase
	endfunction

	function automatic int window_span(input int r);
		case (r)
			0: return 396 - 140;
			1, 2: return 428 - 108;
			default: return 448 - 88;
		endcase
	endfunction

	function automatic logic kind_fits(input logic [13:0] a, input logic [1:0] k);
		if (k[1])
			return a[13:10] == 4'b1000;	// glyph fetch
		return (a[13] == 1'b0) && (a[6] == k[0]);
	endfunction

	// requests sampled on the rising edge
	always @(posedge clk) begin
		rst_q <= rst_n;
		rst_old <= !rst_n;
		if (!rst_n) begin
			pending <= 1'b0;
			left <= 3'd0;
		end else if (video_req) begin
			rng = lcg(rng);
			req_cnt++;
			pending <= 1'b1;
			left <= 3'((rng >> 16) % 32'd6);	// 1 to 6 cycles
			req_addr <= video_addr;
		end else if (left != 3'd0) begin
			left <= left - 3'd1;
		end else if (video_strb) begin
			pending <= 1'b0;
		end
	end

	always @(negedge clk) begin
		video_strb <= pending && (left == 3'd0);
		video_data <= dram_word(req_addr);
	end

	assign is_text = (vconf[2:0] == video_pkg::vm_text);
	assign tx_on = is_text && tx_live && (tx_gap < 5'd16);

	always @(posedge clk) begin
		if (!rst_n || !is_text) begin
			tx_live <= 1'b0;
			tx_gap <= 5'd31;
		end else if (video_req) begin
			tx_gap <= 5'd0;
			if (tx_on) begin
				tx_prev <= tx_prev + 2'd1;
				if (tx_prev == 2'd1)
					glyph_cnt++;
			end else begin
				tx_live <= !video_addr[13] && !video_addr[6];	// start on a char fetch
				tx_prev <= 2'd0;
			end
			if (!video_addr[13] && !video_addr[6])
				tx_char0 <= char0_of(video_addr);
		end else if (tx_gap != 5'd31) begin
			tx_gap <= tx_gap + 5'd1;
		end
	end

	a_reset: assert property (@(posedge clk) ((!rst_n && rst_old) || (rst_n && !rst_q))
		|-> (!video_req && !pix_en && pix == 8'd0))
		else begin $display("[FAIL] %0t: outputs not low around reset", $time); errors++; end
	a_bw: assert property (@(posedge clk) disable iff (!rst_n)
		bw_listed(vconf[2:0]) |-> video_bw == bw_expect(vconf[2:0]))
		else begin $display("[FAIL] %0t: video_bw %b in mode %0d", $time, video_bw,
			vconf[2:0]); errors++; end
	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		vconf[2:0] == 3'd7 |-> !video_req && pix == 8'd0)
		else begin $display("[FAIL] %0t: activity with graphics off", $time); errors++; end
	a_zx_addr: assert property (@(posedge clk) disable iff (!rst_n)
		video_req && vconf[2:0] == 3'd0 |-> video_addr[20:13] == vpage && !video_addr[12])
		else begin $display("[FAIL] %0t: zx address %h", $time, video_addr); errors++; end
	a_256_addr: assert property (@(posedge clk) disable iff (!rst_n)
		video_req && vconf[2:0] == 3'd2 |-> video_addr[20:17] == vpage[7:4])
		else begin $display("[FAIL] %0t: 256c address %h", $time, video_addr); errors++; end
	a_one_req: assert property (@(posedge clk) disable iff (!rst_n) pending |-> !video_req)
		else begin $display("[FAIL] %0t: request while one is in flight", $time); errors++; end
	a_tx_order: assert property (@(posedge clk) disable iff (!rst_n)
		tx_on && video_req |-> kind_fits(video_addr[13:0], tx_prev + 2'd1))
		else begin $display("[FAIL] %0t: text fetch out of order at %h", $time,
			video_addr); errors++; end
	a_tx_glyph: assert property (@(posedge clk) disable iff (!rst_n)
		tx_on && video_req && tx_prev == 2'd1 |-> video_addr[9:2] == tx_char0)
		else begin $display("[FAIL] %0t: glyph0 address %h, char0 %h", $time, video_addr,
			tx_char0); errors++; end

	task automatic next_run_start();
		while (pix_en)
			@(negedge clk);
		while (!pix_en)
			@(negedge clk);
	endtask

	task automatic wait_runs(input int n);
		repeat (n) begin
			next_run_start();
			while (pix_en)
				@(negedge clk);
		end
	endtask

	task automatic measure_run(output int len);
		len = 0;
		while (pix_en) begin
			len++;
			@(negedge clk);
		end
	endtask

	task automatic expect_requests(input int n0, input string what);
		if (req_cnt == n0) begin
			$display("no DRAM request was seen in %s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err0);
			tests_bad++;
		end
	endtask

	initial begin : watchdog
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result after %0d clocks", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		int len;
		int err0;
		int n0;
		rst_n = 1'b0;
		vconf = 8'd0;
		vpage = 8'd0;
		x_offs = 9'd0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		err0 = errors;
		for (int r = 0; r < 4; r++) begin
			vconf = {2'(r), 6'd0};
			wait_runs(1);	// first run may be partial
			next_run_start();
			measure_run(len);
			assert (len == window_span(r) * `VID_DIV)
			else begin
				$display("[FAIL] %0t: resolution %0d, pix_en high %0d clocks, expected %0d",
					$time, r, len, window_span(r) * `VID_DIV);
				errors++;
			end
		end
		report_test("window", err0);

		err0 = errors;
		for (int m = 0; m < 8; m++) begin
			vconf = {5'd0, 3'(m)};
			if (m == 7)
				wait_runs(2);
			else
				repeat (4) @(negedge clk);
		end
		report_test("bandwidth", err0);

		err0 = errors;
		n0 = req_cnt;
		vconf = 8'h00;
		vpage = 8'ha5;
		wait_runs(2);
		expect_requests(n0, "ZX mode");
		n0 = req_cnt;
		vconf = {2'd1, 3'd0, 3'd2};
		vpage = 8'h5e;
		wait_runs(2);
		expect_requests(n0, "256c mode");
		report_test("addresses", err0);

		// random latency comes from the model
		err0 = errors;
		n0 = req_cnt;
		vconf = {2'd3, 3'd0, 3'd1};
		vpage = 8'h3c;
		x_offs = 9'd37;
		wait_runs(3);
		expect_requests(n0, "16c mode");
		x_offs = 9'd0;
		report_test("dram rule", err0);

		err0 = errors;
		n0 = glyph_cnt;
		vconf = {2'd0, 3'd0, 3'd3};
		vpage = 8'h92;
		wait_runs(3);
		if (glyph_cnt == n0) begin
			$display("no glyph0 request followed a char request in text mode");
			errors++;
		end
		report_test("text", err0);

		err0 = errors;
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		report_test("reset", err0);

		$display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== video_sub.f ====
+incdir+logic
logic/video_pkg.sv
logic/video_sync.sv
logic/video_mode.sv
logic/video_fetch.sv
logic/video_render.sv
logic/video_top.sv
test/video_tb.sv
